// File: hdl/isa_pkg.sv
package isa_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int OPC_W     = 6;

    typedef logic [XLEN-1:0]      addr_t;
    typedef logic [XLEN-1:0]      inst_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // primary opcodes
    localparam logic [OPC_W-1:0] OPC_SPECIAL = 6'h00;
    localparam logic [OPC_W-1:0] OPC_REGIMM  = 6'h01;
    localparam logic [OPC_W-1:0] OPC_J       = 6'h02;
    localparam logic [OPC_W-1:0] OPC_JAL     = 6'h03;
    localparam logic [OPC_W-1:0] OPC_BEQ     = 6'h04;
    localparam logic [OPC_W-1:0] OPC_BNE     = 6'h05;
    localparam logic [OPC_W-1:0] OPC_BLEZ    = 6'h06;
    localparam logic [OPC_W-1:0] OPC_BGTZ    = 6'h07;
    localparam logic [OPC_W-1:0] OPC_ADDI    = 6'h08;
    localparam logic [OPC_W-1:0] OPC_ADDIU   = 6'h09;
    localparam logic [OPC_W-1:0] OPC_SLTI    = 6'h0a;
    localparam logic [OPC_W-1:0] OPC_SLTIU   = 6'h0b;
    localparam logic [OPC_W-1:0] OPC_ANDI    = 6'h0c;
    localparam logic [OPC_W-1:0] OPC_ORI     = 6'h0d;
    localparam logic [OPC_W-1:0] OPC_XORI    = 6'h0e;
    localparam logic [OPC_W-1:0] OPC_LUI     = 6'h0f;
    localparam logic [OPC_W-1:0] OPC_LB      = 6'h20;
    localparam logic [OPC_W-1:0] OPC_LH      = 6'h21;
    localparam logic [OPC_W-1:0] OPC_LW      = 6'h23;
    localparam logic [OPC_W-1:0] OPC_LBU     = 6'h24;
    localparam logic [OPC_W-1:0] OPC_LHU     = 6'h25;
    localparam logic [OPC_W-1:0] OPC_SB      = 6'h28;
    localparam logic [OPC_W-1:0] OPC_SH      = 6'h29;
    localparam logic [OPC_W-1:0] OPC_SW      = 6'h2b;

    // function codes under OPC_SPECIAL
    localparam logic [OPC_W-1:0] FUNC_SLL  = 6'h00;
    localparam logic [OPC_W-1:0] FUNC_SRL  = 6'h02;
    localparam logic [OPC_W-1:0] FUNC_SRA  = 6'h03;
    localparam logic [OPC_W-1:0] FUNC_SLLV = 6'h04;
    localparam logic [OPC_W-1:0] FUNC_SRLV = 6'h06;
    localparam logic [OPC_W-1:0] FUNC_SRAV = 6'h07;
    localparam logic [OPC_W-1:0] FUNC_JR   = 6'h08;
    localparam logic [OPC_W-1:0] FUNC_JALR = 6'h09;
    localparam logic [OPC_W-1:0] FUNC_ADD  = 6'h20;
    localparam logic [OPC_W-1:0] FUNC_ADDU = 6'h21;
    localparam logic [OPC_W-1:0] FUNC_SUB  = 6'h22;
    localparam logic [OPC_W-1:0] FUNC_SUBU = 6'h23;
    localparam logic [OPC_W-1:0] FUNC_AND  = 6'h24;
    localparam logic [OPC_W-1:0] FUNC_OR   = 6'h25;
    localparam logic [OPC_W-1:0] FUNC_XOR  = 6'h26;
    localparam logic [OPC_W-1:0] FUNC_NOR  = 6'h27;
    localparam logic [OPC_W-1:0] FUNC_SLT  = 6'h2a;
    localparam logic [OPC_W-1:0] FUNC_SLTU = 6'h2b;

    // rt codes under OPC_REGIMM
    localparam reg_idx_t RT_BLTZ   = 5'h00;
    localparam reg_idx_t RT_BGEZ   = 5'h01;
    localparam reg_idx_t RT_BLTZAL = 5'h10;
    localparam reg_idx_t RT_BGEZAL = 5'h11;

    localparam reg_idx_t LINK_REG = 5'd31;
    localparam addr_t    RESET_PC = 32'hbfc0_0000;
    localparam addr_t    PC_STEP  = 32'd4;

endpackage

// File: hdl/sb_pkg.sv
package sb_pkg;

    typedef logic [2:0] fu_id_t;

    localparam fu_id_t FU_ALU0 = 3'd0;
    localparam fu_id_t FU_ALU1 = 3'd1;
    localparam fu_id_t FU_BRU  = 3'd2;
    localparam fu_id_t FU_LSU  = 3'd3;
    localparam fu_id_t FU_ALU2 = 3'd4;
    localparam fu_id_t FU_ALU3 = 3'd5;

    // one-hot op within a unit, msb first
    // alu:    add sub slt sltu and nor or xor sll srl sra lui
    // branch: beq bne bgez bgtz blez bltz bgezal bltzal j jal jr jalr
    // memory: upper four zero, then lb lbu lh lhu lw sb sh sw
    localparam int OP_W = 12;
    localparam int MEM_OP_W = 8;

    typedef logic [OP_W-1:0] op_vec_t;

    localparam int NUM_ALU   = 4;
    localparam int ALU_PTR_W = $clog2(NUM_ALU);

    typedef logic [2:0] credit_t;

    localparam credit_t DISPATCH_CREDITS = 3'd4;

endpackage

// File: hdl/fetch_align.sv
`timescale 1ns/100ps

module fetch_align import isa_pkg::*; (
    input  logic  clk,
    input  logic  resetn,
    input  logic  fetch_valid,
    input  addr_t fetch_pc,
    input  inst_t fetch_inst,
    output logic  fetch_stall,
    input  logic  redirect_valid,
    input  addr_t redirect_pc,
    input  logic  dec_take,
    output logic  dec_valid,
    output addr_t dec_pc,
    output inst_t dec_inst
);

    addr_t exp_pc;
    logic  buf_valid;
    addr_t buf_pc;
    inst_t buf_inst;
    logic  dec_free;
    logic  accept;

    // decode register can load this cycle
    assign dec_free = ~dec_valid | dec_take;

    // a word is only taken with the stall low, so the buffer is empty here
    assign accept = fetch_valid & ~buf_valid & ~redirect_valid & (fetch_pc == exp_pc);

    assign fetch_stall = buf_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exp_pc    <= RESET_PC;
            dec_valid <= 1'b0;
            buf_valid <= 1'b0;
        end else if (redirect_valid) begin
            exp_pc    <= redirect_pc;
            dec_valid <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            if (accept) begin
                exp_pc <= exp_pc + PC_STEP;
            end
            if (buf_valid) begin
                // drain buffer first
                if (dec_free) begin
                    dec_valid <= 1'b1;
                    buf_valid <= 1'b0;
                end
            end else if (accept) begin
                if (dec_free) begin
                    dec_valid <= 1'b1;
                end else begin
                    buf_valid <= 1'b1;
                end
            end else if (dec_free) begin
                dec_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_free && buf_valid) begin
            dec_pc   <= buf_pc;
            dec_inst <= buf_inst;
        end else if (dec_free && accept) begin
            dec_pc   <= fetch_pc;
            dec_inst <= fetch_inst;
        end
        if (accept && !dec_free) begin
            buf_pc   <= fetch_pc;
            buf_inst <= fetch_inst;
        end
    end

endmodule

// File: hdl/inst_decode.sv
`timescale 1ns/100ps

module inst_decode import isa_pkg::*; import sb_pkg::*; (
    input  inst_t    dec_inst,
    output reg_idx_t rs,
    output reg_idx_t rt,
    output reg_idx_t rd,
    output reg_idx_t sa,
    output op_vec_t  alu_op,
    output op_vec_t  br_op,
    output op_vec_t  mem_op,
    output logic     known
);

    logic [OPC_W-1:0] opcode;
    logic [OPC_W-1:0] func;
    logic special;
    logic regimm;
    logic r3_form;
    logic sh_form;
    logic op_add, op_sub, op_slt, op_sltu;
    logic op_and, op_nor, op_or, op_xor;
    logic op_sll, op_srl, op_sra, op_lui;
    logic logic_mem;

    assign opcode = dec_inst[31:26];
    assign rs     = dec_inst[25:21];
    assign rt     = dec_inst[20:16];
    assign rd     = dec_inst[15:11];
    assign sa     = dec_inst[10:6];
    assign func   = dec_inst[5:0];

    assign special = opcode == OPC_SPECIAL;
    assign regimm  = opcode == OPC_REGIMM;
    // three-register forms need sa zero, immediate shifts need rs zero
    assign r3_form = special & (sa == '0);
    assign sh_form = special & (rs == '0);

    assign op_add  = r3_form & (func == FUNC_ADD | func == FUNC_ADDU)
                   | opcode == OPC_ADDI | opcode == OPC_ADDIU;
    assign op_sub  = r3_form & (func == FUNC_SUB | func == FUNC_SUBU);
    assign op_slt  = r3_form & func == FUNC_SLT | opcode == OPC_SLTI;
    assign op_sltu = r3_form & func == FUNC_SLTU | opcode == OPC_SLTIU;
    assign op_and  = r3_form & func == FUNC_AND | opcode == OPC_ANDI;
    assign op_nor  = r3_form & func == FUNC_NOR;
    assign op_or   = r3_form & func == FUNC_OR | opcode == OPC_ORI;
    assign op_xor  = r3_form & func == FUNC_XOR | opcode == OPC_XORI;
    assign op_sll  = sh_form & func == FUNC_SLL | r3_form & func == FUNC_SLLV;
    assign op_srl  = sh_form & func == FUNC_SRL | r3_form & func == FUNC_SRLV;
    assign op_sra  = sh_form & func == FUNC_SRA | r3_form & func == FUNC_SRAV;
    // lui has rs reserved as zero
    assign op_lui  = opcode == OPC_LUI & rs == '0;

    assign alu_op = {
        op_add, op_sub, op_slt, op_sltu,
        op_and, op_nor, op_or,  op_xor,
        op_sll, op_srl, op_sra, op_lui
    };

    assign br_op = {
        opcode == OPC_BEQ,
        opcode == OPC_BNE,
        regimm & rt == RT_BGEZ,
        opcode == OPC_BGTZ & rt == '0,
        opcode == OPC_BLEZ & rt == '0,
        regimm & rt == RT_BLTZ,
        regimm & rt == RT_BGEZAL,
        regimm & rt == RT_BLTZAL,
        opcode == OPC_J,
        opcode == OPC_JAL,
        r3_form & rt == '0 & rd == '0 & func == FUNC_JR,
        r3_form & rt == '0 & func == FUNC_JALR
    };

    assign mem_op = {
        {(OP_W - MEM_OP_W){1'b0}},
        opcode == OPC_LB,
        opcode == OPC_LBU,
        opcode == OPC_LH,
        opcode == OPC_LHU,
        opcode == OPC_LW,
        opcode == OPC_SB,
        opcode == OPC_SH,
        opcode == OPC_SW
    };

    assign logic_mem = |mem_op;
    assign known = (|alu_op) | (|br_op) | logic_mem;

endmodule

// File: hdl/operand_gen.sv
`timescale 1ns/100ps

module operand_gen import isa_pkg::*; import sb_pkg::*; (
    input  inst_t    dec_inst,
    input  addr_t    dec_pc,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  reg_idx_t rd,
    input  reg_idx_t sa,
    input  op_vec_t  alu_op,
    input  op_vec_t  br_op,
    input  op_vec_t  mem_op,
    output reg_idx_t src1,
    output logic     src1_valid,
    output reg_idx_t src2,
    output logic     src2_valid,
    output reg_idx_t dst,
    output logic     we,
    output addr_t    imm,
    output logic     use_imm1,
    output logic     use_imm2
);

    logic reg_form;
    logic imm_form;
    logic shift_imm;
    logic zext_form;
    logic sext_form;
    logic branch_off;
    logic jump_tgt;
    logic link;
    logic load;
    logic store;

    assign reg_form  = (|alu_op) & (dec_inst[31:26] == OPC_SPECIAL);
    assign imm_form  = (|alu_op) & (dec_inst[31:26] != OPC_SPECIAL);
    // sll, srl, sra; the v forms have func bit 2 set
    assign shift_imm = reg_form & (|alu_op[3:1]) & ~dec_inst[2];
    // andi, ori, xori
    assign zext_form = imm_form & (alu_op[7] | alu_op[5] | alu_op[4]);
    assign load      = |mem_op[7:3];
    assign store     = |mem_op[2:0];
    assign sext_form = (imm_form & ~zext_form) | load | store;
    assign branch_off = |br_op[11:4];
    assign jump_tgt  = br_op[3] | br_op[2];
    // bgezal, bltzal, jal, jalr
    assign link      = br_op[5] | br_op[4] | br_op[2] | br_op[0];

    assign src1 = rs;
    assign src2 = rt;

    assign src1_valid = (reg_form & ~shift_imm) | (imm_form & ~alu_op[0])
                      | load | store | ((|br_op) & ~jump_tgt);
    // beq and bne compare two registers
    assign src2_valid = reg_form | br_op[11] | br_op[10] | store;

    assign we = reg_form | imm_form | load | link;

    always_comb begin
        dst = '0;
        if (link) begin
            dst = LINK_REG;
        end else if (reg_form) begin
            dst = rd;
        end else if (imm_form || load) begin
            dst = rt;
        end
    end

    always_comb begin
        imm = '0;
        if (shift_imm) begin
            imm = {27'b0, sa};
        end else if (sext_form) begin
            imm = {{16{dec_inst[15]}}, dec_inst[15:0]};
        end else if (zext_form) begin
            imm = {16'b0, dec_inst[15:0]};
        end else if (branch_off) begin
            imm = {{14{dec_inst[15]}}, dec_inst[15:0], 2'b00};
        end else if (jump_tgt) begin
            imm = {dec_pc[31:28], dec_inst[25:0], 2'b00};
        end
    end

    assign use_imm1 = shift_imm;
    assign use_imm2 = sext_form | zext_form;

endmodule

// File: hdl/fu_dispatch.sv
`timescale 1ns/100ps

module fu_dispatch import sb_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  logic    dec_valid,
    input  logic    known,
    input  op_vec_t alu_op,
    input  op_vec_t br_op,
    input  op_vec_t mem_op,
    input  logic    credit_return,
    output logic    dec_take,
    output logic    issue_valid,
    output fu_id_t  issue_fu,
    output op_vec_t issue_op
);

    credit_t credits;
    logic [ALU_PTR_W-1:0] alu_ptr;
    logic has_credit;
    logic is_alu;

    assign has_credit = credits != '0;
    assign is_alu     = |alu_op;

    assign issue_valid = dec_valid & known & has_credit;
    // unknown words are dropped without a credit
    assign dec_take    = dec_valid & (~known | has_credit);
    assign issue_op    = alu_op | br_op | mem_op;

    always_comb begin
        issue_fu = FU_ALU0;
        if (|br_op) begin
            issue_fu = FU_BRU;
        end else if (|mem_op) begin
            issue_fu = FU_LSU;
        end else begin
            case (alu_ptr)
                0:       issue_fu = FU_ALU0;
                1:       issue_fu = FU_ALU1;
                2:       issue_fu = FU_ALU2;
                default: issue_fu = FU_ALU3;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            credits <= DISPATCH_CREDITS;
        end else begin
            credits <= credits + credit_t'(credit_return) - credit_t'(issue_valid);
        end
    end

    // round robin over the four alus
    always_ff @(posedge clk) begin
        if (!resetn) begin
            alu_ptr <= '0;
        end else if (issue_valid && is_alu) begin
            alu_ptr <= alu_ptr + 1'b1;
        end
    end

endmodule

// File: hdl/decode_top.sv
`timescale 1ns/100ps

module decode_top import isa_pkg::*; import sb_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     fetch_valid,
    input  addr_t    fetch_pc,
    input  inst_t    fetch_inst,
    output logic     fetch_stall,
    input  logic     redirect_valid,
    input  addr_t    redirect_pc,
    input  logic     credit_return,
    output logic     issue_valid,
    output fu_id_t   issue_fu,
    output op_vec_t  issue_op,
    output reg_idx_t issue_src1,
    output logic     issue_src1_valid,
    output reg_idx_t issue_src2,
    output logic     issue_src2_valid,
    output reg_idx_t issue_dst,
    output logic     issue_we,
    output addr_t    issue_imm,
    output logic     issue_use_imm1,
    output logic     issue_use_imm2,
    output addr_t    issue_pc
);

    logic     dec_valid;
    addr_t    dec_pc;
    inst_t    dec_inst;
    logic     dec_take;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    reg_idx_t sa;
    op_vec_t  alu_op;
    op_vec_t  br_op;
    op_vec_t  mem_op;
    logic     known;

    assign issue_pc = dec_pc;

    fetch_align fetch_align_i (
        .clk            (clk),
        .resetn         (resetn),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_inst     (fetch_inst),
        .fetch_stall    (fetch_stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .dec_take       (dec_take),
        .dec_valid      (dec_valid),
        .dec_pc         (dec_pc),
        .dec_inst       (dec_inst)
    );

    inst_decode inst_decode_i (
        .dec_inst (dec_inst),
        .rs       (rs),
        .rt       (rt),
        .rd       (rd),
        .sa       (sa),
        .alu_op   (alu_op),
        .br_op    (br_op),
        .mem_op   (mem_op),
        .known    (known)
    );

    operand_gen operand_gen_i (
        .dec_inst   (dec_inst),
        .dec_pc     (dec_pc),
        .rs         (rs),
        .rt         (rt),
        .rd         (rd),
        .sa         (sa),
        .alu_op     (alu_op),
        .br_op      (br_op),
        .mem_op     (mem_op),
        .src1       (issue_src1),
        .src1_valid (issue_src1_valid),
        .src2       (issue_src2),
        .src2_valid (issue_src2_valid),
        .dst        (issue_dst),
        .we         (issue_we),
        .imm        (issue_imm),
        .use_imm1   (issue_use_imm1),
        .use_imm2   (issue_use_imm2)
    );

    fu_dispatch fu_dispatch_i (
        .clk           (clk),
        .resetn        (resetn),
        .dec_valid     (dec_valid),
        .known         (known),
        .alu_op        (alu_op),
        .br_op         (br_op),
        .mem_op        (mem_op),
        .credit_return (credit_return),
        .dec_take      (dec_take),
        .issue_valid   (issue_valid),
        .issue_fu      (issue_fu),
        .issue_op      (issue_op)
    );

endmodule

// File: dv/decode_assert.sv
`timescale 1ns/100ps

module decode_assert import sb_pkg::*; (
    input logic clk,
    input logic resetn,
    input logic issue_valid,
    input logic credit_return,
    input logic fetch_stall,
    input logic dec_valid,
    input logic redirect_valid
);

    credit_t avail;

    // credits as the scoreboard sees them
    always_ff @(posedge clk) begin
        if (!resetn) begin
            avail <= DISPATCH_CREDITS;
        end else if (credit_return && !issue_valid) begin
            avail <= avail + 1'b1;
        end else if (issue_valid && !credit_return) begin
            avail <= avail - 1'b1;
        end
    end

    credit_ok: assert property (@(posedge clk) disable iff (!resetn)
        issue_valid |-> avail != '0)
        else $error("issue without a credit");

    // buffer only fills behind a held decode register
    stall_ok: assert property (@(posedge clk) disable iff (!resetn)
        fetch_stall |-> dec_valid)
        else $error("fetch_stall high with the decode register empty");

    // redirect flushes the decode register
    flush_ok: assert property (@(posedge clk) disable iff (!resetn)
        redirect_valid |=> !issue_valid)
        else $error("issue in the cycle after a redirect");

endmodule

bind decode_top decode_assert decode_assert_i (
    .clk            (clk),
    .resetn         (resetn),
    .issue_valid    (issue_valid),
    .credit_return  (credit_return),
    .fetch_stall    (fetch_stall),
    .dec_valid      (dec_valid),
    .redirect_valid (redirect_valid)
);

// File: dv/decode_tb.sv
`timescale 1ns/100ps

module decode_tb import isa_pkg::*; import sb_pkg::*; ();

    typedef struct packed {
        addr_t    pc;
        logic [1:0]  cls;
        op_vec_t  op;
        reg_idx_t src1;
        reg_idx_t src2;
        reg_idx_t dst;
        logic     we;
        addr_t    imm;
        logic [1:0]  use_imm;
        logic [1:0]  src_valid;
    } exp_t;

    logic     clk;
    logic     resetn;
    logic     fetch_valid;
    addr_t    fetch_pc;
    inst_t    fetch_inst;
    logic     fetch_stall;
    logic     redirect_valid;
    addr_t    redirect_pc;
    logic     credit_return;
    logic     issue_valid;
    fu_id_t   issue_fu;
    op_vec_t  issue_op;
    reg_idx_t issue_src1;
    logic     issue_src1_valid;
    reg_idx_t issue_src2;
    logic     issue_src2_valid;
    reg_idx_t issue_dst;
    logic     issue_we;
    addr_t    issue_imm;
    logic     issue_use_imm1;
    logic     issue_use_imm2;
    addr_t    issue_pc;

    exp_t exp_q[$];
    exp_t e_in;
    exp_t e_out;
    addr_t exp_pc;
    logic [1:0] rr_ptr;
    fu_id_t exp_fu;
    logic [31:0] lfsr;
    logic stall_seen;
    int errors;
    int issued;
    int pushed;
    int fd;
    int nfields;
    string line;
    logic [31:0] f_pc, f_inst, f_rv, f_rpc, f_cr, f_iss, f_cls;
    logic [31:0] f_op, f_dst, f_we, f_imm, f_ui, f_sv;

    decode_top decode_top_i (.*);

    always #20 clk = ~clk;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic finish_run();
        $display("errors: %0d  issued: %0d of %0d", errors, issued, pushed);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
        finish_run();
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_stall_low();
        int n;
        n = 0;
        while (fetch_stall) begin
            @(negedge clk);
            n++;
            if (n > 200) begin
                timed_out("fetch_stall to fall");
            end
        end
    endtask

    // everything pushed has issued and nothing is issuing now
    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0 || issue_valid) begin
            @(negedge clk);
            n++;
            if (n > 500) begin
                timed_out("expected issues to drain");
            end
        end
    endtask

    task automatic run_line();
        int gap;
        gap = 0;
        repeat (2) begin
            lfsr = lfsr_step(lfsr);
            gap = (gap << 1) | lfsr[0];
        end
        repeat (gap) @(negedge clk);
        if (f_rv[0]) begin
            wait_drained();
        end
        wait_stall_low();
        fetch_valid = 1'b1;
        fetch_pc = f_pc;
        fetch_inst = f_inst;
        redirect_valid = f_rv[0];
        redirect_pc = f_rpc;
        if (f_rv[0]) begin
            // the word presented with a redirect is dropped
            exp_pc = f_rpc;
        end else if (f_pc == exp_pc) begin
            // pc filter of the model
            exp_pc = exp_pc + PC_STEP;
            if (f_iss[0]) begin
                e_in = '{f_pc, f_cls[1:0], f_op[11:0], f_inst[25:21], f_inst[20:16],
                         f_dst[4:0], f_we[0], f_imm, f_ui[1:0], f_sv[1:0]};
                exp_q.push_back(e_in);
                pushed++;
            end
        end
        @(negedge clk);
        fetch_valid = 1'b0;
        redirect_valid = 1'b0;
        repeat (f_cr) begin
            credit_return = 1'b1;
            @(negedge clk);
            credit_return = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (resetn) begin
            if (fetch_stall) begin
                stall_seen = 1'b1;
            end
            if (issue_valid) begin
                if (exp_q.size() == 0) begin
                    $display("issue at pc %h with no word expected", issue_pc);
                    errors++;
                end else begin
                    e_out = exp_q.pop_front();
                    case (e_out.cls)
                        2'd1: exp_fu = FU_BRU;
                        2'd2: exp_fu = FU_LSU;
                        default: begin
                            exp_fu = (rr_ptr == 0) ? FU_ALU0 : (rr_ptr == 1) ? FU_ALU1 :
                                     (rr_ptr == 2) ? FU_ALU2 : FU_ALU3;
                            rr_ptr = rr_ptr + 1'b1;
                        end
                    endcase
                    check("issue_pc", issue_pc, e_out.pc);
                    check("issue_fu", issue_fu, exp_fu);
                    check("issue_op", issue_op, e_out.op);
                    check("issue_dst", issue_dst, e_out.dst);
                    check("issue_we", issue_we, e_out.we);
                    check("issue_imm", issue_imm, e_out.imm);
                    check("issue_use_imm", {issue_use_imm1, issue_use_imm2}, e_out.use_imm);
                    check("issue_src_valid", {issue_src1_valid, issue_src2_valid},
                          e_out.src_valid);
                    // source indices only matter where marked valid
                    if (e_out.src_valid[1]) begin
                        check("issue_src1", issue_src1, e_out.src1);
                    end
                    if (e_out.src_valid[0]) begin
                        check("issue_src2", issue_src2, e_out.src2);
                    end
                    issued++;
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc = '0;
        fetch_inst = '0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        credit_return = 1'b0;
        lfsr = 32'hd5a;
        exp_pc = RESET_PC;
        rr_ptr = '0;
        stall_seen = 1'b0;
        errors = 0;
        issued = 0;
        pushed = 0;
        repeat (10) @(negedge clk);
        resetn = 1'b1;
        fd = $fopen("dv/decode_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file dv/decode_input.txt");
            errors++;
            finish_run();
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0) begin
                    break;
                end
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                nfields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  f_pc, f_inst, f_rv, f_rpc, f_cr, f_iss, f_cls,
                                  f_op, f_dst, f_we, f_imm, f_ui, f_sv);
                if (nfields != 13) begin
                    $display("stimulus line has %0d fields instead of 13", nfields);
                    errors++;
                end else begin
                    run_line();
                end
            end
            $fclose(fd);
            wait_drained();
            check("fetch_stall_seen", stall_seen, 1);
            finish_run();
        end
    end

endmodule

// File: dv/decode_input.txt
# pc inst redirect redirect_pc credit_returns issues class(0 alu 1 br 2 mem)
# op dst we imm use_imm(imm1 imm2) src_valid(src1 src2), all hex
bfc00000 00221820 0 00000000 1 1 0 800 03 1 00000000 0 3
bfc00004 2085fffe 0 00000000 1 1 0 800 05 1 fffffffe 1 2
bfc00008 10220003 0 00000000 1 1 1 800 00 0 0000000c 0 3
bfc0000c 34c78001 0 00000000 1 1 0 020 07 1 00008001 1 2
bfc00010 8d28fffc 0 00000000 1 1 2 008 08 1 fffffffc 1 2
bfc00014 000b5140 0 00000000 1 1 0 008 0a 1 00000005 2 1
bfc00018 adac0008 0 00000000 1 1 2 001 00 0 00000008 1 3
bfc0001c fc000000 0 00000000 0 0 0 000 00 0 00000000 0 0
bfc00020 0c100040 0 00000000 1 1 1 004 1f 1 b0400100 0 0
bfc00024 00430822 0 00000000 1 1 0 400 01 1 00000000 0 3
bfc00028 0491ffff 0 00000000 1 1 1 020 1f 1 fffffffc 0 2
bfc0002c 00221820 1 bfc00100 0 0 0 000 00 0 00000000 0 0
bfc00030 00221820 0 00000000 0 0 0 000 00 0 00000000 0 0
bfc00100 03e00008 0 00000000 1 1 1 002 00 0 00000000 0 2
bfc00104 3c021234 0 00000000 1 1 0 001 02 1 00001234 1 0
bfc00108 00430825 0 00000000 0 1 0 020 01 1 00000000 0 3
bfc0010c 00430824 0 00000000 0 1 0 080 01 1 00000000 0 3
bfc00110 00430826 0 00000000 0 1 0 010 01 1 00000000 0 3
bfc00114 00430827 0 00000000 0 1 0 040 01 1 00000000 0 3
bfc00118 0043082a 0 00000000 0 1 0 200 01 1 00000000 0 3
bfc0011c 0043082b 0 00000000 6 1 0 100 01 1 00000000 0 3
bfc00120 00052083 0 00000000 1 1 0 002 04 1 00000002 2 1

// File: vlog.f
hdl/isa_pkg.sv
hdl/sb_pkg.sv
hdl/fetch_align.sv
hdl/inst_decode.sv
hdl/operand_gen.sv
hdl/fu_dispatch.sv
hdl/decode_top.sv
dv/decode_assert.sv
dv/decode_tb.sv

// File: Bender.yml
package:
  name: mips_decode

sources:
  - hdl/isa_pkg.sv
  - hdl/sb_pkg.sv
  - hdl/fetch_align.sv
  - hdl/inst_decode.sv
  - hdl/operand_gen.sv
  - hdl/fu_dispatch.sv
  - hdl/decode_top.sv
  - target: test
    files:
      - dv/decode_assert.sv
      - dv/decode_tb.sv
